// File: logic/read_guard_pkg.sv
//////////////////////////////////////////////////
// Read guard shared sizes, register offsets
// and the outstanding-read slot entry
//////////////////////////////////////////////////

`default_nettype none

package read_guard_pkg;

  // Table and datapath sizes
  localparam int unsigned NumSlots    = 4;
  localparam int unsigned IdWidth     = 4;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned CntWidth    = 16;
  localparam int unsigned WbDataWidth = 32;
  localparam int unsigned WbAddrWidth = 8;

  // Derived widths
  localparam int unsigned SlotIdxWidth = $clog2(NumSlots);
  localparam int unsigned OccWidth     = $clog2(NumSlots + 1);

  // Budget in cycles after reset
  localparam logic [CntWidth-1:0] BudgetReset = 16'd16;

  // Register map, byte offsets
  localparam logic [WbAddrWidth-1:0] RegBudget      = 8'h00;
  localparam logic [WbAddrWidth-1:0] RegStatus      = 8'h04;
  localparam logic [WbAddrWidth-1:0] RegIrqAddr     = 8'h08;
  localparam logic [WbAddrWidth-1:0] RegLatency     = 8'h0C;
  localparam logic [WbAddrWidth-1:0] RegOutstanding = 8'h10;

  // Status bit positions
  localparam int unsigned StatusTimeoutBit  = 0;
  localparam int unsigned StatusUnwantedBit = 1;

  // One outstanding read
  typedef struct packed {
    logic                 busy;
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [CntWidth-1:0]  age;
  } slot_t;

endpackage

`default_nettype wire

// File: logic/guard_event_if.sv
//////////////////////////////////////////////////
// Event and budget signals between the slot
// table and the register block
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface guard_event_if;

  logic                                   retire_valid;
  logic [read_guard_pkg::CntWidth-1:0]    retire_latency;
  logic                                   timeout_valid;
  logic [read_guard_pkg::AddrWidth-1:0]   timeout_addr;
  logic                                   unwanted_valid;
  logic [read_guard_pkg::OccWidth-1:0]    occupancy;
  logic [read_guard_pkg::CntWidth-1:0]    budget;

  modport table_mp (
    output retire_valid, retire_latency, timeout_valid, timeout_addr,
    output unwanted_valid, occupancy,
    input  budget
  );

  modport regs_mp (
    input  retire_valid, retire_latency, timeout_valid, timeout_addr,
    input  unwanted_valid, occupancy,
    output budget
  );

endinterface

`default_nettype wire

// File: logic/txn_slot_table.sv
//////////////////////////////////////////////////
// Outstanding-read table: slot allocation, aging,
// ID match on responses and timeout detection
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module txn_slot_table (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 ar_valid_i,
  input  logic                                 ar_ready_i,
  input  logic [read_guard_pkg::IdWidth-1:0]   ar_id_i,
  input  logic [read_guard_pkg::AddrWidth-1:0] ar_addr_i,
  input  logic                                 r_valid_i,
  input  logic                                 r_ready_i,
  input  logic [read_guard_pkg::IdWidth-1:0]   r_id_i,
  output logic                                 full_o,
  guard_event_if.table_mp                      evt
);

  read_guard_pkg::slot_t [read_guard_pkg::NumSlots-1:0] slot_d, slot_q;

  logic [read_guard_pkg::NumSlots-1:0]     busy;
  logic [read_guard_pkg::NumSlots-1:0]     id_match;
  logic [read_guard_pkg::NumSlots-1:0]     expired;
  logic                                    accept;
  logic                                    rsp_seen;
  logic                                    match_found;
  logic                                    retire;
  logic [read_guard_pkg::SlotIdxWidth-1:0] free_idx;
  logic [read_guard_pkg::SlotIdxWidth-1:0] oldest_idx;
  logic [read_guard_pkg::CntWidth-1:0]     oldest_age;
  logic                                    timeout_hit;
  logic [read_guard_pkg::AddrWidth-1:0]    timeout_addr_d;
  logic                                    timeout_valid_q;
  logic                                    unwanted_valid_q;
  logic [read_guard_pkg::AddrWidth-1:0]    timeout_addr_q;
  logic [read_guard_pkg::OccWidth-1:0]     occupancy;

  assign full_o   = &busy;
  assign accept   = ar_valid_i && ar_ready_i && !full_o;
  assign rsp_seen = r_valid_i && r_ready_i;
  assign retire   = rsp_seen && match_found;

  // Per-slot status flags
  for (genvar i = 0; i < read_guard_pkg::NumSlots; i++) begin : gen_flags
    assign busy[i]     = slot_q[i].busy;
    assign id_match[i] = slot_q[i].busy && (slot_q[i].id == r_id_i);
    // Expires when the edge about to come is the budget-th one
    assign expired[i]  = slot_q[i].busy &&
        (({1'b0, slot_q[i].age} + 1'b1) >= {1'b0, evt.budget});
  end

  // Lowest free slot takes the next read
  always_comb begin
    free_idx = '0;
    for (int i = read_guard_pkg::NumSlots - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_idx = read_guard_pkg::SlotIdxWidth'(i);
      end
    end
  end

  // Oldest busy slot with the response ID, ages are unique among busy slots
  always_comb begin
    match_found = 1'b0;
    oldest_idx  = '0;
    oldest_age  = '0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      if (id_match[i] && (!match_found || (slot_q[i].age > oldest_age))) begin
        match_found = 1'b1;
        oldest_idx  = read_guard_pkg::SlotIdxWidth'(i);
        oldest_age  = slot_q[i].age;
      end
    end
  end

  always_comb begin
    slot_d         = slot_q;
    timeout_hit    = 1'b0;
    timeout_addr_d = '0;
    // Descending walk so the lowest expiring slot supplies the address
    for (int i = read_guard_pkg::NumSlots - 1; i >= 0; i--) begin
      if (slot_q[i].busy) begin
        slot_d[i].age = slot_q[i].age + 1'b1;
      end
      if (retire && (oldest_idx == read_guard_pkg::SlotIdxWidth'(i))) begin
        // Response wins over a timeout on the same edge
        slot_d[i].busy = 1'b0;
      end else if (expired[i]) begin
        slot_d[i].busy = 1'b0;
        timeout_hit    = 1'b1;
        timeout_addr_d = slot_q[i].addr;
      end
    end
    // Only slots free in the current cycle are candidates
    if (accept) begin
      slot_d[free_idx].busy = 1'b1;
      slot_d[free_idx].id   = ar_id_i;
      slot_d[free_idx].addr = ar_addr_i;
      slot_d[free_idx].age  = '0;
    end
  end

  always_comb begin
    occupancy = '0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      occupancy = occupancy + read_guard_pkg::OccWidth'(busy[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q           <= '0;
      timeout_valid_q  <= 1'b0;
      unwanted_valid_q <= 1'b0;
    end else begin
      slot_q           <= slot_d;
      timeout_valid_q  <= timeout_hit;
      unwanted_valid_q <= rsp_seen && !match_found;
    end
  end

  // Address of the expired read, qualified by timeout_valid_q
  always_ff @(posedge clk_i) begin
    if (timeout_hit) begin
      timeout_addr_q <= timeout_addr_d;
    end
  end

  // Latency counts the response edge itself
  assign evt.retire_valid   = retire;
  assign evt.retire_latency = oldest_age + 1'b1;
  assign evt.timeout_valid  = timeout_valid_q;
  assign evt.timeout_addr   = timeout_addr_q;
  assign evt.unwanted_valid = unwanted_valid_q;
  assign evt.occupancy      = occupancy;

endmodule

`default_nettype wire

// File: logic/guard_regs.sv
//////////////////////////////////////////////////
// Wishbone classic register block: budget, status,
// captured address, latency and latched alarm
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module guard_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [read_guard_pkg::WbAddrWidth-1:0] wb_adr_i,
  input  logic [read_guard_pkg::WbDataWidth-1:0] wb_dat_i,
  output logic [read_guard_pkg::WbDataWidth-1:0] wb_dat_o,
  output logic                                   wb_ack_o,
  output logic                                   irq_o,
  output logic                                   reset_req_o,
  guard_event_if.regs_mp                         evt
);

  logic                                 ack_q;
  logic                                 wb_req;
  logic                                 wb_wr;
  logic                                 status_clr;
  logic [read_guard_pkg::CntWidth-1:0]  budget_q;
  logic [read_guard_pkg::CntWidth-1:0]  latency_q;
  logic [1:0]                           status_q;
  logic [read_guard_pkg::AddrWidth-1:0] irq_addr_q;
  logic                                 alarm_q;

  // New access only while no ack is pending, so each access is two cycles
  assign wb_req     = wb_cyc_i && wb_stb_i && !ack_q;
  assign wb_wr      = wb_req && wb_we_i;
  assign status_clr = wb_wr && (wb_adr_i == read_guard_pkg::RegStatus);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      budget_q   <= read_guard_pkg::BudgetReset;
      latency_q  <= '0;
      status_q   <= '0;
      irq_addr_q <= '0;
      alarm_q    <= 1'b0;
    end else begin
      ack_q <= wb_req;
      if (wb_wr && (wb_adr_i == read_guard_pkg::RegBudget)) begin
        budget_q <= wb_dat_i[read_guard_pkg::CntWidth-1:0];
      end
      if (evt.retire_valid) begin
        latency_q <= evt.retire_latency;
      end
      if (evt.timeout_valid) begin
        irq_addr_q <= evt.timeout_addr;
      end
      // Clear first, a new event on the same edge still sets
      if (status_clr) begin
        status_q <= '0;
        alarm_q  <= 1'b0;
      end
      if (evt.timeout_valid) begin
        status_q[read_guard_pkg::StatusTimeoutBit] <= 1'b1;
      end
      if (evt.unwanted_valid) begin
        status_q[read_guard_pkg::StatusUnwantedBit] <= 1'b1;
      end
      if (evt.timeout_valid || evt.unwanted_valid) begin
        alarm_q <= 1'b1;
      end
    end
  end

  // Read data, address held stable until the ack
  always_comb begin
    case (wb_adr_i)
      read_guard_pkg::RegBudget:      wb_dat_o = read_guard_pkg::WbDataWidth'(budget_q);
      read_guard_pkg::RegStatus:      wb_dat_o = read_guard_pkg::WbDataWidth'(status_q);
      read_guard_pkg::RegIrqAddr:     wb_dat_o = read_guard_pkg::WbDataWidth'(irq_addr_q);
      read_guard_pkg::RegLatency:     wb_dat_o = read_guard_pkg::WbDataWidth'(latency_q);
      read_guard_pkg::RegOutstanding: wb_dat_o = read_guard_pkg::WbDataWidth'(evt.occupancy);
      default:                        wb_dat_o = '0;
    endcase
  end

  assign wb_ack_o    = ack_q;
  assign evt.budget  = budget_q;
  // Interrupt and reset request share one latch
  assign irq_o       = alarm_q;
  assign reset_req_o = alarm_q;

endmodule

`default_nettype wire

// File: logic/read_guard_top.sv
//////////////////////////////////////////////////
// Read guard top: slot table, register block
// and request ready masking
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module read_guard_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Read request channel
  input  logic                                   ar_valid_i,
  input  logic [read_guard_pkg::IdWidth-1:0]     ar_id_i,
  input  logic [read_guard_pkg::AddrWidth-1:0]   ar_addr_i,
  input  logic                                   ar_ready_i,
  output logic                                   ar_ready_o,
  // Read response channel, observed only
  input  logic                                   r_valid_i,
  input  logic                                   r_ready_i,
  input  logic [read_guard_pkg::IdWidth-1:0]     r_id_i,
  // Wishbone classic slave
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [read_guard_pkg::WbAddrWidth-1:0] wb_adr_i,
  input  logic [read_guard_pkg::WbDataWidth-1:0] wb_dat_i,
  output logic [read_guard_pkg::WbDataWidth-1:0] wb_dat_o,
  output logic                                   wb_ack_o,
  // Latched alarm outputs
  output logic                                   irq_o,
  output logic                                   reset_req_o
);

  guard_event_if evt ();

  logic table_full;

  // Back-pressure toward the master while every slot is busy
  assign ar_ready_o = ar_ready_i && !table_full;

  txn_slot_table i_table (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .ar_valid_i ( ar_valid_i  ),
    .ar_ready_i ( ar_ready_i  ),
    .ar_id_i    ( ar_id_i     ),
    .ar_addr_i  ( ar_addr_i   ),
    .r_valid_i  ( r_valid_i   ),
    .r_ready_i  ( r_ready_i   ),
    .r_id_i     ( r_id_i      ),
    .full_o     ( table_full  ),
    .evt        ( evt.table_mp )
  );

  guard_regs i_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .wb_cyc_i    ( wb_cyc_i    ),
    .wb_stb_i    ( wb_stb_i    ),
    .wb_we_i     ( wb_we_i     ),
    .wb_adr_i    ( wb_adr_i    ),
    .wb_dat_i    ( wb_dat_i    ),
    .wb_dat_o    ( wb_dat_o    ),
    .wb_ack_o    ( wb_ack_o    ),
    .irq_o       ( irq_o       ),
    .reset_req_o ( reset_req_o ),
    .evt         ( evt.regs_mp )
  );

endmodule

`default_nettype wire

// File: verif/read_guard_checker.sv
//////////////////////////////////////////////////
// Read guard checker: outstanding-read model,
// register reference and per-edge compares
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module read_guard_checker (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   ar_valid_i,
  input logic [read_guard_pkg::IdWidth-1:0]     ar_id_i,
  input logic [read_guard_pkg::AddrWidth-1:0]   ar_addr_i,
  input logic                                   ar_ready_i,
  input logic                                   ar_grant_i,
  input logic                                   r_valid_i,
  input logic                                   r_ready_i,
  input logic [read_guard_pkg::IdWidth-1:0]     r_id_i,
  input logic                                   wb_cyc_i,
  input logic                                   wb_stb_i,
  input logic                                   wb_we_i,
  input logic [read_guard_pkg::WbAddrWidth-1:0] wb_adr_i,
  input logic [read_guard_pkg::WbDataWidth-1:0] wb_wdata_i,
  input logic [read_guard_pkg::WbDataWidth-1:0] wb_rdata_i,
  input logic                                   wb_ack_i,
  input logic                                   irq_i,
  input logic                                   reset_req_i
);

  string       test_name = "reset";
  int unsigned check_count;
  int unsigned mismatch_count;

  // Slot model, indexed like the DUT table
  int                                   edge_n;
  logic                                 m_busy [read_guard_pkg::NumSlots];
  logic [read_guard_pkg::IdWidth-1:0]   m_id   [read_guard_pkg::NumSlots];
  logic [read_guard_pkg::AddrWidth-1:0] m_addr [read_guard_pkg::NumSlots];
  int                                   m_acc  [read_guard_pkg::NumSlots];
  // Register contents after the last edge
  logic [read_guard_pkg::CntWidth-1:0]  m_budget;
  logic [read_guard_pkg::CntWidth-1:0]  m_latency;
  logic [1:0]                           m_status;
  logic [read_guard_pkg::AddrWidth-1:0] m_irq_addr;
  logic                                 m_alarm;
  logic                                 m_ack;
  // Table events that reach the registers one edge later
  logic                                 to_pend;
  logic [read_guard_pkg::AddrWidth-1:0] to_addr_pend;
  logic                                 uw_pend;

  function automatic int busy_count();
    int n;
    n = 0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      n += int'(m_busy[i]);
    end
    return n;
  endfunction

  // Edges from the accepting edge to the response edge
  function automatic logic [read_guard_pkg::CntWidth-1:0] ref_latency(input int acc,
                                                                      input int now);
    return read_guard_pkg::CntWidth'(now - acc);
  endfunction

  function automatic logic [31:0] expect_reg(input logic [read_guard_pkg::WbAddrWidth-1:0] adr);
    case (adr)
      read_guard_pkg::RegBudget:      return 32'(m_budget);
      read_guard_pkg::RegStatus:      return 32'(m_status);
      read_guard_pkg::RegIrqAddr:     return 32'(m_irq_addr);
      read_guard_pkg::RegLatency:     return 32'(m_latency);
      read_guard_pkg::RegOutstanding: return 32'(busy_count());
      default:                        return 32'h0;
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      mismatch_count++;
      $display("Mismatch in %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    end
  endtask

  task automatic reset_model();
    edge_n = 0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      m_busy[i] = 1'b0;
    end
    m_budget   = read_guard_pkg::BudgetReset;
    m_latency  = '0;
    m_status   = '0;
    m_irq_addr = '0;
    m_alarm    = 1'b0;
    m_ack      = 1'b0;
    to_pend    = 1'b0;
    uw_pend    = 1'b0;
  endtask

  task automatic advance_model();
    logic                                 rsp;
    logic                                 found;
    logic                                 accept;
    logic                                 wb_wr;
    logic                                 to_hit;
    logic [read_guard_pkg::AddrWidth-1:0] to_addr;
    logic                                 expire [read_guard_pkg::NumSlots];
    int                                   hit;
    int                                   free_idx;
    edge_n++;
    wb_wr = wb_cyc_i && wb_stb_i && !m_ack && wb_we_i;
    // Status clear first, an event on the same edge still sets
    if (wb_wr && (wb_adr_i == read_guard_pkg::RegStatus)) begin
      m_status = '0;
      m_alarm  = 1'b0;
    end
    if (to_pend) begin
      m_status[read_guard_pkg::StatusTimeoutBit] = 1'b1;
      m_irq_addr = to_addr_pend;
      m_alarm    = 1'b1;
    end
    if (uw_pend) begin
      m_status[read_guard_pkg::StatusUnwantedBit] = 1'b1;
      m_alarm = 1'b1;
    end
    // Oldest outstanding read with the response ID
    rsp   = r_valid_i && r_ready_i;
    found = 1'b0;
    hit   = 0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      if (rsp && m_busy[i] && (m_id[i] == r_id_i) && (!found || (m_acc[i] < m_acc[hit]))) begin
        found = 1'b1;
        hit   = i;
      end
    end
    if (found) begin
      m_latency = ref_latency(m_acc[hit], edge_n);
    end
    // Budget edges without a response, lowest slot gives the address
    to_hit  = 1'b0;
    to_addr = '0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      expire[i] = m_busy[i] && !(found && (i == hit)) &&
                  ((edge_n - m_acc[i]) >= int'(m_budget));
      if (expire[i] && !to_hit) begin
        to_hit  = 1'b1;
        to_addr = m_addr[i];
      end
    end
    accept   = ar_valid_i && ar_ready_i && (busy_count() < read_guard_pkg::NumSlots);
    free_idx = 0;
    for (int i = read_guard_pkg::NumSlots - 1; i >= 0; i--) begin
      if (!m_busy[i]) begin
        free_idx = i;
      end
    end
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      if (expire[i] || (found && (i == hit))) begin
        m_busy[i] = 1'b0;
      end
    end
    if (accept) begin
      m_busy[free_idx] = 1'b1;
      m_id[free_idx]   = ar_id_i;
      m_addr[free_idx] = ar_addr_i;
      m_acc[free_idx]  = edge_n;
    end
    to_pend      = to_hit;
    to_addr_pend = to_addr;
    uw_pend      = rsp && !found;
    if (wb_wr && (wb_adr_i == read_guard_pkg::RegBudget)) begin
      m_budget = wb_wdata_i[read_guard_pkg::CntWidth-1:0];
    end
    m_ack = wb_cyc_i && wb_stb_i && !m_ack;
  endtask

  // DUT outputs still hold their pre-edge values here
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      compare("ar_ready_o",
              32'(ar_ready_i && (busy_count() < read_guard_pkg::NumSlots)), 32'(ar_grant_i));
      compare("wb_ack_o", 32'(m_ack), 32'(wb_ack_i));
      compare("irq_o", 32'(m_alarm), 32'(irq_i));
      compare("reset_req_o", 32'(m_alarm), 32'(reset_req_i));
      if (m_ack && wb_cyc_i && wb_stb_i && !wb_we_i) begin
        compare($sformatf("register 0x%0h", wb_adr_i), expect_reg(wb_adr_i), wb_rdata_i);
      end
      advance_model();
    end
  end

endmodule

`default_nettype wire

// File: verif/read_guard_tb.sv
//////////////////////////////////////////////////
// Read guard testbench: clock, reset, LFSR,
// bus tasks, test sequence and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module read_guard_tb;

  localparam int ClkPeriod   = 100;
  localparam int LatencyRuns = 8;
  // Summed test lengths in bus operations
  localparam int TestLength  = 7 + 3 * LatencyRuns + 8 + 6 + 7 +
                               2 * read_guard_pkg::NumSlots + 5;

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  logic                                   ar_valid;
  logic [read_guard_pkg::IdWidth-1:0]     ar_id;
  logic [read_guard_pkg::AddrWidth-1:0]   ar_addr;
  logic                                   ar_ready_in;
  logic                                   ar_ready_out;
  logic                                   r_valid;
  logic                                   r_ready;
  logic [read_guard_pkg::IdWidth-1:0]     r_id;
  logic                                   wb_cyc;
  logic                                   wb_stb;
  logic                                   wb_we;
  logic [read_guard_pkg::WbAddrWidth-1:0] wb_adr;
  logic [read_guard_pkg::WbDataWidth-1:0] wb_wdata;
  logic [read_guard_pkg::WbDataWidth-1:0] wb_rdata;
  logic                                   wb_ack;
  logic                                   irq;
  logic                                   reset_req;
  logic [31:0]                            lfsr_state = 32'hfa5e0e92;
  int unsigned                            other_errors = 0;

  always #(ClkPeriod / 2) clk = ~clk;

  read_guard_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .ar_valid_i (ar_valid), .ar_id_i (ar_id), .ar_addr_i (ar_addr),
    .ar_ready_i (ar_ready_in), .ar_ready_o (ar_ready_out),
    .r_valid_i (r_valid), .r_ready_i (r_ready), .r_id_i (r_id),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdata), .wb_dat_o (wb_rdata), .wb_ack_o (wb_ack),
    .irq_o (irq), .reset_req_o (reset_req)
  );

  read_guard_checker i_checker (
    .clk_i (clk), .rst_ni (rst_n),
    .ar_valid_i (ar_valid), .ar_id_i (ar_id), .ar_addr_i (ar_addr),
    .ar_ready_i (ar_ready_in), .ar_grant_i (ar_ready_out),
    .r_valid_i (r_valid), .r_ready_i (r_ready), .r_id_i (r_id),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_wdata_i (wb_wdata), .wb_rdata_i (wb_rdata), .wb_ack_i (wb_ack),
    .irq_i (irq), .reset_req_i (reset_req)
  );

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Starts at a falling edge and holds the bus until the ack cycle ends
  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] data);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = data;
    @(negedge clk);
    while (!wb_ack && (waited < 10)) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack) begin
      other_errors++;
      $display("Wishbone access to 0x%0h got no ack", adr);
    end
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] adr);
    wb_access(1'b0, adr, 32'h0);
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] data);
    wb_access(1'b1, adr, data);
  endtask

  task automatic start_read(input logic [3:0] id, input logic [31:0] addr);
    ar_valid = 1'b1;
    ar_id    = id;
    ar_addr  = addr;
  endtask

  // Ready sampled in the middle of the low phase
  task automatic wait_accept();
    logic granted;
    int   waited;
    granted = 1'b0;
    waited  = 0;
    while (!granted && (waited < 20)) begin
      #(ClkPeriod / 4);
      granted = ar_ready_out;
      @(negedge clk);
      waited++;
    end
    ar_valid = 1'b0;
    if (!granted) begin
      other_errors++;
      $display("Read request was not accepted in time");
    end
  endtask

  task automatic send_response(input logic [3:0] id);
    r_valid = 1'b1;
    r_id    = id;
    @(negedge clk);
    r_valid = 1'b0;
  endtask

  initial begin
    logic [read_guard_pkg::IdWidth-1:0]   id;
    logic [read_guard_pkg::IdWidth-1:0]   ids [read_guard_pkg::NumSlots];
    logic [read_guard_pkg::AddrWidth-1:0] addr;
    int                                   delay;
    rst_n       = 1'b0;
    ar_valid    = 1'b0;
    ar_id       = '0;
    ar_addr     = '0;
    ar_ready_in = 1'b1;
    r_valid     = 1'b0;
    r_ready     = 1'b1;
    r_id        = '0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_wdata    = '0;
    idle(2);
    rst_n = 1'b1;
    idle(1);

    i_checker.test_name = "reset_values";
    read_reg(read_guard_pkg::RegBudget);
    read_reg(read_guard_pkg::RegStatus);
    read_reg(read_guard_pkg::RegIrqAddr);
    read_reg(read_guard_pkg::RegLatency);
    read_reg(read_guard_pkg::RegOutstanding);
    write_reg(read_guard_pkg::RegBudget, 32'd32);
    read_reg(read_guard_pkg::RegBudget);

    i_checker.test_name = "single_latency";
    for (int k = 0; k < LatencyRuns; k++) begin
      id    = 4'(rand_bits(4));
      addr  = rand_bits(32);
      delay = 1 + int'(rand_bits(4));
      start_read(id, addr);
      wait_accept();
      idle(delay - 1);
      send_response(id);
      read_reg(read_guard_pkg::RegLatency);
    end

    i_checker.test_name = "same_id_order";
    id = 4'(rand_bits(4));
    start_read(id, rand_bits(32));
    wait_accept();
    idle(3);
    start_read(id, rand_bits(32));
    wait_accept();
    idle(2);
    read_reg(read_guard_pkg::RegOutstanding);
    send_response(id);
    read_reg(read_guard_pkg::RegLatency);
    read_reg(read_guard_pkg::RegOutstanding);
    send_response(id);

    i_checker.test_name = "timeout";
    write_reg(read_guard_pkg::RegBudget, 32'd5);
    start_read(4'(rand_bits(4)), rand_bits(32));
    wait_accept();
    idle(8);
    read_reg(read_guard_pkg::RegStatus);
    read_reg(read_guard_pkg::RegIrqAddr);
    write_reg(read_guard_pkg::RegStatus, 32'h0);
    read_reg(read_guard_pkg::RegStatus);

    // Nothing outstanding, so any ID is unexpected
    i_checker.test_name = "unwanted";
    // Without r_ready the beat is not a response
    r_ready = 1'b0;
    send_response(4'(rand_bits(4)));
    r_ready = 1'b1;
    idle(2);
    read_reg(read_guard_pkg::RegStatus);
    send_response(4'(rand_bits(4)));
    idle(3);
    read_reg(read_guard_pkg::RegStatus);
    write_reg(read_guard_pkg::RegStatus, 32'hffff_ffff);
    read_reg(read_guard_pkg::RegStatus);

    i_checker.test_name = "full_table";
    write_reg(read_guard_pkg::RegBudget, 32'd200);
    // Slave not ready at first, so the first read waits
    ar_ready_in = 1'b0;
    for (int k = 0; k < read_guard_pkg::NumSlots; k++) begin
      ids[k] = 4'(rand_bits(4));
      start_read(ids[k], rand_bits(32));
      if (k == 0) begin
        idle(3);
        ar_ready_in = 1'b1;
      end
      wait_accept();
    end
    read_reg(read_guard_pkg::RegOutstanding);
    id = 4'(rand_bits(4));
    start_read(id, rand_bits(32));
    idle(4);
    send_response(ids[0]);
    wait_accept();
    read_reg(read_guard_pkg::RegOutstanding);
    for (int k = 1; k < read_guard_pkg::NumSlots; k++) begin
      send_response(ids[k]);
    end
    send_response(id);
    read_reg(read_guard_pkg::RegOutstanding);
    idle(4);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             i_checker.check_count, i_checker.mismatch_count, other_errors);
    if ((i_checker.mismatch_count == 0) && (other_errors == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(TestLength * 200 * ClkPeriod);
    $display("Watchdog expired before the test sequence finished");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: read_guard_top.f
logic/read_guard_pkg.sv
logic/guard_event_if.sv
logic/txn_slot_table.sv
logic/guard_regs.sv
logic/read_guard_top.sv
verif/read_guard_checker.sv
verif/read_guard_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the read guard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module read_guard_tb -f read_guard_top.f
sim_out="$(./obj_dir/Vread_guard_tb)"
echo "$sim_out"

if grep -q 'All tests passed!' <<< "$sim_out"; then
  exit 0
fi
exit 1
